// ==== sources.f ====
+incdir+.
rv32i_types_pkg.sv
pipe5_types_pkg.sv
pipe5_insn_decode.sv
pipe5_dest_tracker.sv
pipe5_hazard_forwarding_unit.sv
pipe5_hazard_top.sv
tb_pipe5_hazard.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build from the file list, run, and pass only if the pass line shows up
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module tb_pipe5_hazard \
        -f sources.f -o sim_pipe5_hazard \
    && ./obj_dir/sim_pipe5_hazard | tee /dev/stderr | grep -q "TEST OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== pipe5_hazard_patterns.txt ====
// insn valid f_busy x_busy m_busy mispredict, then expected pc_en stall flush bypass_rs1 bypass_rs2
// stall and flush digits: bit 3 fd, bit 2 dx, bit 1 xm, bit 0 mw
00000000 0 0 0 0 0 1 0 0 0 0
00500093 1 0 0 0 0 1 0 0 0 0
00108133 1 0 0 0 0 1 0 0 0 0
002081b3 1 0 0 0 0 1 0 0 1 1
00000013 1 0 0 0 0 1 0 0 2 1
00000013 1 0 0 0 0 1 0 0 0 0
00318033 1 0 0 0 0 1 0 0 0 0
000002b3 1 0 0 0 0 1 0 0 0 0
00000013 1 0 0 0 0 1 0 0 0 0
001021a3 1 0 0 0 0 1 0 0 0 0
00018333 1 0 0 0 0 1 0 0 0 0
00000013 1 0 0 0 0 1 0 0 0 0
00000013 1 0 0 0 0 1 0 0 0 0
00002383 1 0 0 0 0 1 0 0 0 0
00038433 1 0 0 0 0 0 8 4 0 0
00038433 1 0 0 0 0 1 0 0 0 0
00000013 1 0 0 0 0 1 0 0 2 0
00000013 1 0 0 0 0 1 0 0 0 0
0000006f 1 0 0 0 0 1 0 0 0 0
00000013 1 0 0 0 0 1 0 0 0 0
00500093 1 0 0 0 0 1 0 e 0 0
00000063 1 0 0 0 0 1 0 0 0 0
00000013 1 0 0 0 0 1 0 0 0 0
00000013 1 0 0 0 0 1 0 0 0 0
00000063 1 0 0 0 0 1 0 0 0 0
00000013 1 0 0 0 0 1 0 0 0 0
00500093 1 0 0 0 1 1 0 e 0 0
00000013 1 0 0 0 1 1 0 0 0 0
00500093 1 0 0 0 0 1 0 0 0 0
00108133 1 0 0 0 0 1 0 0 0 0
002081b3 1 0 0 1 0 0 f 0 1 1
002081b3 1 0 1 0 0 0 c 2 1 1
002081b3 1 1 0 0 0 0 0 8 2 2
00000000 0 0 0 0 0 1 0 0 0 1
00002383 1 0 0 0 0 1 0 0 0 0
00038433 1 0 0 1 0 0 f 0 0 0
00038433 1 0 0 0 0 0 8 4 0 0
00038433 1 0 0 0 0 1 0 0 0 0
00000013 1 0 0 0 0 1 0 0 2 0
00000000 0 0 0 0 0 1 0 0 0 0

// ==== tb_pipe5_hazard.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pipe5_defs.svh"

module tb_pipe5_hazard;

    import pipe5_types_pkg::*;

    // Words per pattern line
    // insn, valid, f_busy, x_busy, m_busy, mispredict, pc_en, stalls, flushes, two selects
    localparam logic [8:0] COLS = 9'd11;
    // Reset cycles, every pattern line, and some slack
    localparam int WATCHDOG_CYCLES = `PATTERN_COUNT + 20;

    logic             clk;
    logic             reset;
    logic [`XLEN-1:0] d_insn;
    logic             d_valid;
    logic             f_busy;
    logic             x_busy;
    logic             m_busy;
    logic             mispredict_m;
    logic             pc_en;
    logic             fd_stall;
    logic             dx_stall;
    logic             xm_stall;
    logic             mw_stall;
    logic             fd_flush;
    logic             dx_flush;
    logic             xm_flush;
    logic             mw_flush;
    fwd_sel_e         bypass_rs1;
    fwd_sel_e         bypass_rs2;

    // Whole pattern file with COLS words per cycle
    logic [31:0] pattern_mem [0:COLS*`PATTERN_COUNT-1];
    logic [8:0]  row;

    pipe5_hazard_top uut (
        .clk          (clk),
        .reset        (reset),
        .d_insn       (d_insn),
        .d_valid      (d_valid),
        .f_busy       (f_busy),
        .x_busy       (x_busy),
        .m_busy       (m_busy),
        .mispredict_m (mispredict_m),
        .pc_en        (pc_en),
        .fd_stall     (fd_stall),
        .dx_stall     (dx_stall),
        .xm_stall     (xm_stall),
        .mw_stall     (mw_stall),
        .fd_flush     (fd_flush),
        .dx_flush     (dx_flush),
        .xm_flush     (xm_flush),
        .mw_flush     (mw_flush),
        .bypass_rs1   (bypass_rs1),
        .bypass_rs2   (bypass_rs2)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Applies the inputs of one pattern line at a rising edge
    task drive_line(input logic [8:0] base);
        d_insn       <= pattern_mem[base];
        d_valid      <= pattern_mem[base + 9'd1][0];
        f_busy       <= pattern_mem[base + 9'd2][0];
        x_busy       <= pattern_mem[base + 9'd3][0];
        m_busy       <= pattern_mem[base + 9'd4][0];
        mispredict_m <= pattern_mem[base + 9'd5][0];
    endtask

    task automatic check_flag(input string name, input int line, input logic actual,
                              input logic expected);
        assert (actual === expected) else begin
            $display("mismatch %s at line %0d: expected %h, actual %h",
                     name, line, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_select(input string name, input int line, input logic [1:0] actual,
                                input logic [1:0] expected);
        assert (actual === expected) else begin
            $display("mismatch %s at line %0d: expected %h, actual %h",
                     name, line, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // Stall and flush nibbles hold fd in bit 3, dx in bit 2, xm in bit 1 and mw in bit 0
    task automatic check_line(input logic [8:0] base, input int line);
        logic [3:0] stall_exp;
        logic [3:0] flush_exp;
        stall_exp = pattern_mem[base + 9'd7][3:0];
        flush_exp = pattern_mem[base + 9'd8][3:0];
        check_flag("pc_en", line, pc_en, pattern_mem[base + 9'd6][0]);
        check_flag("fd_stall", line, fd_stall, stall_exp[3]);
        check_flag("dx_stall", line, dx_stall, stall_exp[2]);
        check_flag("xm_stall", line, xm_stall, stall_exp[1]);
        check_flag("mw_stall", line, mw_stall, stall_exp[0]);
        check_flag("fd_flush", line, fd_flush, flush_exp[3]);
        check_flag("dx_flush", line, dx_flush, flush_exp[2]);
        check_flag("xm_flush", line, xm_flush, flush_exp[1]);
        check_flag("mw_flush", line, mw_flush, flush_exp[0]);
        check_select("bypass_rs1", line, bypass_rs1, pattern_mem[base + 9'd9][1:0]);
        check_select("bypass_rs2", line, bypass_rs2, pattern_mem[base + 9'd10][1:0]);
    endtask

    // Stimulus and checking
    initial begin
        reset        = 1'b1;
        d_insn       = '0;
        d_valid      = 1'b0;
        f_busy       = 1'b0;
        x_busy       = 1'b0;
        m_busy       = 1'b0;
        mispredict_m = 1'b0;
        row          = '0;
        $readmemh("pipe5_hazard_patterns.txt", pattern_mem);

        // Five reset edges with quiet inputs
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
        end
        reset <= 1'b0;

        // Drive on the rising edge and check at the falling edge once outputs settle
        for (int line = 0; line < `PATTERN_COUNT; line++) begin
            drive_line(row);
            @(negedge clk);
            check_line(row, line);
            row = row + COLS;
            @(posedge clk);
        end

        $display("TEST OK");
        $finish;
    end

    // Watchdog on the whole run
    initial begin
        for (int cycle = 0; cycle < WATCHDOG_CYCLES; cycle++) begin
            @(posedge clk);
        end
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== pipe5_hazard_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pipe5_defs.svh"

module pipe5_hazard_top (
    input  wire logic                         clk,
    input  wire logic                         reset,
    input  wire rv32i_types_pkg::rv32i_insn_u d_insn,
    input  wire logic                         d_valid,
    input  wire logic                         f_busy,
    input  wire logic                         x_busy,
    input  wire logic                         m_busy,
    input  wire logic                         mispredict_m,
    output logic                              pc_en,
    output logic                              fd_stall,
    output logic                              dx_stall,
    output logic                              xm_stall,
    output logic                              mw_stall,
    output logic                              fd_flush,
    output logic                              dx_flush,
    output logic                              xm_flush,
    output logic                              mw_flush,
    output pipe5_types_pkg::fwd_sel_e         bypass_rs1,
    output pipe5_types_pkg::fwd_sel_e         bypass_rs2
);

    import pipe5_types_pkg::*;

    // Decode-stage fields
    logic [`REG_ADDR_W-1:0] rs1_d;
    logic [`REG_ADDR_W-1:0] rs2_d;
    logic [`REG_ADDR_W-1:0] rd_d;
    producer_e              prod_d;
    logic                   uses_rs1_d;
    logic                   uses_rs2_d;
    logic                   jump_d;
    logic                   branch_d;

    // In-flight state seen by the hazard checks
    logic [`REG_ADDR_W-1:0] rd_x;
    producer_e              prod_x;
    logic [`REG_ADDR_W-1:0] rs1_x;
    logic [`REG_ADDR_W-1:0] rs2_x;
    logic [`REG_ADDR_W-1:0] rd_m;
    logic                   jump_m;
    logic                   branch_m;
    logic [`REG_ADDR_W-1:0] rd_w;

    pipe5_insn_decode u_decode (
        .d_insn     (d_insn),
        .d_valid    (d_valid),
        .rs1_d      (rs1_d),
        .rs2_d      (rs2_d),
        .rd_d       (rd_d),
        .prod_d     (prod_d),
        .uses_rs1_d (uses_rs1_d),
        .uses_rs2_d (uses_rs2_d),
        .jump_d     (jump_d),
        .branch_d   (branch_d)
    );

    // Records advance under the stall and flush this cycle computes
    pipe5_dest_tracker u_tracker (
        .clk      (clk),
        .reset    (reset),
        .d_valid  (d_valid),
        .rs1_d    (rs1_d),
        .rs2_d    (rs2_d),
        .rd_d     (rd_d),
        .prod_d   (prod_d),
        .jump_d   (jump_d),
        .branch_d (branch_d),
        .dx_stall (dx_stall),
        .dx_flush (dx_flush),
        .xm_stall (xm_stall),
        .xm_flush (xm_flush),
        .mw_stall (mw_stall),
        .mw_flush (mw_flush),
        .rd_x     (rd_x),
        .prod_x   (prod_x),
        .rs1_x    (rs1_x),
        .rs2_x    (rs2_x),
        .rd_m     (rd_m),
        .jump_m   (jump_m),
        .branch_m (branch_m),
        .rd_w     (rd_w)
    );

    pipe5_hazard_forwarding_unit u_hazard (
        .rs1_d        (rs1_d),
        .rs2_d        (rs2_d),
        .uses_rs1_d   (uses_rs1_d),
        .uses_rs2_d   (uses_rs2_d),
        .rd_x         (rd_x),
        .prod_x       (prod_x),
        .rs1_x        (rs1_x),
        .rs2_x        (rs2_x),
        .rd_m         (rd_m),
        .jump_m       (jump_m),
        .branch_m     (branch_m),
        .rd_w         (rd_w),
        .f_busy       (f_busy),
        .x_busy       (x_busy),
        .m_busy       (m_busy),
        .mispredict_m (mispredict_m),
        .pc_en        (pc_en),
        .fd_stall     (fd_stall),
        .dx_stall     (dx_stall),
        .xm_stall     (xm_stall),
        .mw_stall     (mw_stall),
        .fd_flush     (fd_flush),
        .dx_flush     (dx_flush),
        .xm_flush     (xm_flush),
        .mw_flush     (mw_flush),
        .bypass_rs1   (bypass_rs1),
        .bypass_rs2   (bypass_rs2)
    );

endmodule

`default_nettype wire

// ==== pipe5_hazard_forwarding_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pipe5_defs.svh"

module pipe5_hazard_forwarding_unit (
    input  wire logic                   [`REG_ADDR_W-1:0] rs1_d,
    input  wire logic                   [`REG_ADDR_W-1:0] rs2_d,
    input  wire logic                   uses_rs1_d,
    input  wire logic                   uses_rs2_d,
    input  wire logic                   [`REG_ADDR_W-1:0] rd_x,
    input  wire pipe5_types_pkg::producer_e prod_x,
    input  wire logic                   [`REG_ADDR_W-1:0] rs1_x,
    input  wire logic                   [`REG_ADDR_W-1:0] rs2_x,
    input  wire logic                   [`REG_ADDR_W-1:0] rd_m,
    input  wire logic                   jump_m,
    input  wire logic                   branch_m,
    input  wire logic                   [`REG_ADDR_W-1:0] rd_w,
    input  wire logic                   f_busy,
    input  wire logic                   x_busy,
    input  wire logic                   m_busy,
    input  wire logic                   mispredict_m,
    output logic                        pc_en,
    output logic                        fd_stall,
    output logic                        dx_stall,
    output logic                        xm_stall,
    output logic                        mw_stall,
    output logic                        fd_flush,
    output logic                        dx_flush,
    output logic                        xm_flush,
    output logic                        mw_flush,
    output pipe5_types_pkg::fwd_sel_e   bypass_rs1,
    output pipe5_types_pkg::fwd_sel_e   bypass_rs2
);

    import pipe5_types_pkg::*;

    logic raw_hazard;
    logic ctl_hazard;

    // Load-use or CSR-use: the value exists only after M, so no bypass can cover it
    // x0 is never a real dependency
    assign raw_hazard = (rd_x != '0) && (prod_x == PROD_LATE)
                        && ((uses_rs1_d && rd_x == rs1_d)
                            || (uses_rs2_d && rd_x == rs2_d));

    // Redirect resolved in M, everything younger is on the wrong path
    assign ctl_hazard = jump_m || (branch_m && mispredict_m);

    // Youngest producer wins, M before W
    always_comb begin
        if (rs1_x == rd_m && rd_m != '0) begin
            bypass_rs1 = FWD_M;
        end else if (rs1_x == rd_w && rd_w != '0) begin
            bypass_rs1 = FWD_W;
        end else begin
            bypass_rs1 = NO_FWD;
        end
    end

    always_comb begin
        if (rs2_x == rd_m && rd_m != '0) begin
            bypass_rs2 = FWD_M;
        end else if (rs2_x == rd_w && rd_w != '0) begin
            bypass_rs2 = FWD_W;
        end else begin
            bypass_rs2 = NO_FWD;
        end
    end

    // Stall and flush, highest priority first
    always_comb begin
        pc_en    = 1'b1;
        fd_stall = 1'b0;
        dx_stall = 1'b0;
        xm_stall = 1'b0;
        mw_stall = 1'b0;
        fd_flush = 1'b0;
        dx_flush = 1'b0;
        xm_flush = 1'b0;
        mw_flush = 1'b0;
        if (ctl_hazard) begin
            // PC keeps running to pick up the redirect target
            fd_flush = 1'b1;
            dx_flush = 1'b1;
            xm_flush = 1'b1;
        end else if (m_busy) begin
            // Whole pipe freezes, W held so its bypass stays valid
            fd_stall = 1'b1;
            dx_stall = 1'b1;
            xm_stall = 1'b1;
            mw_stall = 1'b1;
            pc_en    = 1'b0;
        end else if (x_busy) begin
            // Multicycle op in X, M and W drain behind a bubble
            fd_stall = 1'b1;
            dx_stall = 1'b1;
            xm_flush = 1'b1;
            pc_en    = 1'b0;
        end else if (raw_hazard) begin
            // Hold the consumer in D one cycle, producer moves on to M
            fd_stall = 1'b1;
            dx_flush = 1'b1;
            pc_en    = 1'b0;
        end else if (f_busy) begin
            // Fetch not ready, feed a bubble downstream
            fd_flush = 1'b1;
            pc_en    = 1'b0;
        end
    end

    // Stall and flush on one register are contradictory
    // A frozen PC must be matched by a held or killed fetch slot
    always_comb begin
        assert (!(fd_stall && fd_flush) && !(dx_stall && dx_flush)
                && !(xm_stall && xm_flush) && !(mw_stall && mw_flush))
            else $error("hazard: register stalled and flushed together");
        assert (pc_en || fd_stall || fd_flush)
            else $error("hazard: pc held without fd stall or flush");
    end

endmodule

`default_nettype wire

// ==== pipe5_dest_tracker.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pipe5_defs.svh"

module pipe5_dest_tracker (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   d_valid,
    input  wire logic [`REG_ADDR_W-1:0] rs1_d,
    input  wire logic [`REG_ADDR_W-1:0] rs2_d,
    input  wire logic [`REG_ADDR_W-1:0] rd_d,
    input  wire pipe5_types_pkg::producer_e prod_d,
    input  wire logic                   jump_d,
    input  wire logic                   branch_d,
    input  wire logic                   dx_stall,
    input  wire logic                   dx_flush,
    input  wire logic                   xm_stall,
    input  wire logic                   xm_flush,
    input  wire logic                   mw_stall,
    input  wire logic                   mw_flush,
    output logic [`REG_ADDR_W-1:0]      rd_x,
    output pipe5_types_pkg::producer_e  prod_x,
    output logic [`REG_ADDR_W-1:0]      rs1_x,
    output logic [`REG_ADDR_W-1:0]      rs2_x,
    output logic [`REG_ADDR_W-1:0]      rd_m,
    output logic                        jump_m,
    output logic                        branch_m,
    output logic [`REG_ADDR_W-1:0]      rd_w
);

    import pipe5_types_pkg::*;

    logic valid_x;
    logic jump_x;
    logic branch_x;
    logic valid_m;
    logic valid_w;

    // Execute record, fed from decode
    // An empty decode slot enters as a bubble
    always_ff @(posedge clk) begin
        if (reset || (!dx_stall && (dx_flush || !d_valid))) begin
            valid_x  <= 1'b0;
            rd_x     <= '0;
            prod_x   <= PROD_NONE;
            rs1_x    <= '0;
            rs2_x    <= '0;
            jump_x   <= 1'b0;
            branch_x <= 1'b0;
        end else if (!dx_stall) begin
            valid_x  <= 1'b1;
            rd_x     <= rd_d;
            prod_x   <= prod_d;
            rs1_x    <= rs1_d;
            rs2_x    <= rs2_d;
            jump_x   <= jump_d;
            branch_x <= branch_d;
        end
    end

    // Memory record, only what the hazard checks still need
    always_ff @(posedge clk) begin
        if (reset || (!xm_stall && xm_flush)) begin
            valid_m  <= 1'b0;
            rd_m     <= '0;
            jump_m   <= 1'b0;
            branch_m <= 1'b0;
        end else if (!xm_stall) begin
            valid_m  <= valid_x;
            rd_m     <= rd_x;
            jump_m   <= jump_x;
            branch_m <= branch_x;
        end
    end

    // Writeback record, destination only for the W bypass
    always_ff @(posedge clk) begin
        if (reset || (!mw_stall && mw_flush)) begin
            valid_w <= 1'b0;
            rd_w    <= '0;
        end else if (!mw_stall) begin
            valid_w <= valid_m;
            rd_w    <= rd_m;
        end
    end

    // Bubbles carry no destination anywhere down the pipe
    assert property (@(posedge clk) disable iff (reset) !valid_x |-> rd_x == '0);
    assert property (@(posedge clk) disable iff (reset) !valid_m |-> rd_m == '0);
    assert property (@(posedge clk) disable iff (reset) !valid_w |-> rd_w == '0);

endmodule

`default_nettype wire

// ==== pipe5_insn_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "pipe5_defs.svh"

module pipe5_insn_decode (
    input  wire rv32i_types_pkg::rv32i_insn_u d_insn,
    input  wire logic                         d_valid,
    output logic [`REG_ADDR_W-1:0]            rs1_d,
    output logic [`REG_ADDR_W-1:0]            rs2_d,
    output logic [`REG_ADDR_W-1:0]            rd_d,
    output pipe5_types_pkg::producer_e        prod_d,
    output logic                              uses_rs1_d,
    output logic                              uses_rs2_d,
    output logic                              jump_d,
    output logic                              branch_d
);

    import rv32i_types_pkg::*;
    import pipe5_types_pkg::*;

    rv32i_opcode_e    opcode;
    logic             writes_rd;
    logic             known_op;
    logic [`XLEN-1:0] insn_bits;

    // Opcode lives in the same low bits for every format
    assign opcode    = d_insn.r_view.opcode;
    assign insn_bits = d_insn;

    // Instruction class
    always_comb begin
        writes_rd  = 1'b0;
        known_op   = 1'b1;
        prod_d     = PROD_NONE;
        uses_rs1_d = 1'b1;
        uses_rs2_d = 1'b0;
        jump_d     = 1'b0;
        branch_d   = 1'b0;
        case (opcode)
            LOAD: begin
                writes_rd = 1'b1;
                prod_d    = PROD_LATE;
            end
            STORE: begin
                uses_rs2_d = 1'b1;
            end
            OP: begin
                writes_rd  = 1'b1;
                prod_d     = PROD_ALU;
                uses_rs2_d = 1'b1;
            end
            OP_IMM: begin
                writes_rd = 1'b1;
                prod_d    = PROD_ALU;
            end
            BRANCH: begin
                uses_rs2_d = 1'b1;
                branch_d   = 1'b1;
            end
            JAL: begin
                writes_rd  = 1'b1;
                prod_d     = PROD_ALU;
                uses_rs1_d = 1'b0;
                jump_d     = 1'b1;
            end
            JALR: begin
                writes_rd = 1'b1;
                prod_d    = PROD_ALU;
                jump_d    = 1'b1;
            end
            LUI, AUIPC: begin
                writes_rd  = 1'b1;
                prod_d     = PROD_ALU;
                uses_rs1_d = 1'b0;
            end
            // CSR access returns its value late like a load
            SYSTEM: begin
                writes_rd = 1'b1;
                prod_d    = PROD_LATE;
            end
            default: begin
                known_op   = 1'b0;
                uses_rs1_d = 1'b0;
            end
        endcase
    end

    // Source fields sit at the same bits in every format
    assign rs1_d = d_insn.r_view.rs1;
    assign rs2_d = d_insn.r_view.rs2;

    // imm_lo of an S/B word overlays rd and only real writers expose it
    assign rd_d = writes_rd ? d_insn.r_view.rd : '0;

    // Environment must never present a valid slot with garbage in it
    always_comb begin
        if (d_valid) begin
            assert (known_op && !$isunknown(insn_bits))
                else $error("decode: valid word %h has unknown opcode", insn_bits);
        end
    end

endmodule

`default_nettype wire

// ==== pipe5_types_pkg.sv ====
`default_nettype none

package pipe5_types_pkg;

    // Source of an execute-stage operand
    typedef enum logic [1:0] {
        // Value read from the register file in decode
        NO_FWD = 2'd0,
        // Result sitting in the memory stage
        FWD_M  = 2'd1,
        // Result sitting in writeback
        FWD_W  = 2'd2
    } fwd_sel_e;

    // When an instruction's result becomes available
    typedef enum logic [1:0] {
        // No register write at all
        PROD_NONE = 2'd0,
        // Result ready at the end of execute
        PROD_ALU  = 2'd1,
        // Loads and CSR reads, ready only after memory
        PROD_LATE = 2'd2
    } producer_e;

endpackage

`default_nettype wire

// ==== rv32i_types_pkg.sv ====
`default_nettype none

`include "pipe5_defs.svh"

package rv32i_types_pkg;

    // Major opcodes the hazard logic needs to tell apart
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        OP_IMM = 7'b0010011,
        AUIPC  = 7'b0010111,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011
    } rv32i_opcode_e;

    // Register-register layout
    // I, U and J words share the rd and opcode positions
    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        rv32i_opcode_e          opcode;
    } rv32i_r_view_t;

    // Store and branch layout
    // The low immediate bits sit where other formats keep rd
    typedef struct packed {
        logic [6:0]             imm_hi;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] imm_lo;
        rv32i_opcode_e          opcode;
    } rv32i_sb_view_t;

    // One instruction word, two readings of the same bits
    typedef union packed {
        rv32i_r_view_t  r_view;
        rv32i_sb_view_t sb_view;
    } rv32i_insn_u;

endpackage

`default_nettype wire

// ==== pipe5_defs.svh ====
`ifndef PIPE5_DEFS_SVH
`define PIPE5_DEFS_SVH

// Architectural register address width, x0..x31
`define REG_ADDR_W 5

// Instruction word width of the base integer set
`define XLEN 32

// Stimulus lines in the pattern file, one per clock cycle
`define PATTERN_COUNT 40

`endif
